//--- files.f
hw/trace_pkg.sv
hw/rx_trace_front.sv
hw/trace_ram.sv
hw/trace_capture.sv
hw/lb_regs.sv
hw/lb_readback.sv
hw/trace_bus_top.sv
tb/tb_trace_bus.sv

//--- hw/lb_readback.sv
module lb_readback #(
   parameter int TRACE_AW = 11
) (
   input  logic                   fp_clk,
   input  logic                   reset,
   input  trace_pkg::lb_cmd_t     lb_cmd,
   input  logic                   trace_req,
   input  trace_pkg::trace_word_t trace_rdata,
   output logic [31:0]            rd_data
);

   logic [2:0] sel;

   // Trace window is selected by addr[12], so the memory must fit below it
   if (TRACE_AW > 12) begin : g_aw_check
      $error("TRACE_AW of %0d overlaps the readback select bit", TRACE_AW);
   end

   assign sel = {lb_cmd.addr[12], lb_cmd.addr[1:0]};

   always_ff @(posedge fp_clk) begin
      if (reset) begin
         rd_data <= trace_pkg::TXT_GOOD;
      end else begin
         case (sel)
            3'd0: rd_data <= trace_pkg::TXT_GOOD;
            3'd1: rd_data <= trace_pkg::TXT_BYE;
            // Shows whether a trace request is still pending
            3'd2: rd_data <= trace_req ? trace_pkg::TXT_DAVI : trace_pkg::TXT_WORL;
            3'd3: rd_data <= trace_pkg::TXT_TAIL;
            default: rd_data <= trace_rdata;
         endcase
      end
   end

endmodule

//--- hw/lb_regs.sv
module lb_regs (
   input  logic                  fp_clk,
   input  logic                  reset,
   input  trace_pkg::lb_cmd_t    lb_cmd,
   input  logic                  trace_done,
   output trace_pkg::ctrl_regs_t ctrl,
   output logic                  trace_req
);

   logic       wr;
   logic [7:0] wr_addr;
   logic       wr_trace;

   assign wr       = lb_cmd.strobe && !lb_cmd.rd;
   assign wr_addr  = lb_cmd.addr[7:0];
   assign wr_trace = wr && (wr_addr == trace_pkg::ADDR_TRACE);

   always_ff @(posedge fp_clk) begin
      if (reset) begin
         ctrl <= trace_pkg::CTRL_RESET;
      end else if (wr) begin
         case (wr_addr)
            trace_pkg::ADDR_POWER: begin
               ctrl.power_conf <= lb_cmd.wdata[3:0];
            end
            trace_pkg::ADDR_TRACE: begin
               ctrl.trace_nowait <= lb_cmd.wdata[0];
            end
            trace_pkg::ADDR_LINK: begin
               ctrl.rd_hack   <= lb_cmd.wdata[1];
               ctrl.an_bypass <= lb_cmd.wdata[0];
            end
            trace_pkg::ADDR_MANGLE: begin
               ctrl.nomangle <= lb_cmd.wdata[0];
            end
            default: begin
               ctrl <= ctrl;
            end
         endcase
      end
   end

   // Request flag, set by software and taken down by the capture side
   always_ff @(posedge fp_clk) begin
      if (reset) begin
         trace_req <= 1'b0;
      end else begin
         if (wr_trace) begin
            trace_req <= 1'b1;
         end
         if (trace_done) begin
            trace_req <= 1'b0;
         end
      end
   end

   a_req_from_write: assert property (
      @(posedge fp_clk) disable iff (reset)
      $rose(trace_req) |-> $past(wr_trace)
   );

endmodule

//--- hw/rx_trace_front.sv
module rx_trace_front (
   input  logic                   fp_clk,
   input  logic                   reset,
   input  trace_pkg::gmii_rx_t    gmii_rx,
   output trace_pkg::trace_word_t trace_in,
   output logic                   trig
);

   // Pins registered once, as they would be in the IOB
   trace_pkg::gmii_rx_t    rx_q;
   trace_pkg::trace_word_t word_new;
   trace_pkg::trace_word_t word_d1;
   trace_pkg::trace_word_t word_d2;

   always_ff @(posedge fp_clk) begin
      if (reset) begin
         rx_q <= '0;
      end else begin
         rx_q <= gmii_rx;
      end
   end

   // Trace word built from the registered pins
   always_comb begin
      word_new      = '0;
      word_new.tag  = trace_pkg::TRACE_TAG;
      word_new.dv   = rx_q.dv;
      word_new.er   = rx_q.er;
      word_new.rxd  = rx_q.rxd;
   end

   // Two-deep history; the older word is what gets stored,
   // so the trace shows the sample before the trigger as well
   always_ff @(posedge fp_clk) begin
      if (reset) begin
         word_d1 <= '0;
         word_d2 <= '0;
      end else begin
         word_d1 <= word_new;
         word_d2 <= word_d1;
      end
   end

   assign trace_in = word_d2;

   // Any change of rxd or er across two samples fires the trigger
   assign trig = {word_new.er, word_new.rxd} != {word_d2.er, word_d2.rxd};

endmodule

//--- hw/trace_bus_top.sv
module trace_bus_top #(
   parameter int TRACE_AW = 11
) (
   input  logic                  fp_clk,
   input  logic                  reset,
   input  trace_pkg::gmii_rx_t   gmii_rx,
   input  trace_pkg::lb_cmd_t    lb_cmd,
   output logic [31:0]           rd_data,
   output trace_pkg::ctrl_regs_t ctrl
);

   trace_pkg::trace_word_t trace_in;
   trace_pkg::trace_word_t trace_rdata;
   logic                   trig;
   logic                   trace_req;
   logic                   trace_done;

   // Input side
   rx_trace_front rx_trace_front_inst (
      .fp_clk  (fp_clk),
      .reset   (reset),
      .gmii_rx (gmii_rx),
      .trace_in(trace_in),
      .trig    (trig)
   );

   // Capture engine; memory is read straight from the bus address
   trace_capture #(
      .TRACE_AW(TRACE_AW)
   ) trace_capture_inst (
      .fp_clk      (fp_clk),
      .reset       (reset),
      .trace_in    (trace_in),
      .trig        (trig),
      .trace_req   (trace_req),
      .trace_nowait(ctrl.trace_nowait),
      .raddr       (lb_cmd.addr[TRACE_AW-1:0]),
      .trace_done  (trace_done),
      .trace_rdata (trace_rdata)
   );

   // Bus side
   lb_regs lb_regs_inst (
      .fp_clk    (fp_clk),
      .reset     (reset),
      .lb_cmd    (lb_cmd),
      .trace_done(trace_done),
      .ctrl      (ctrl),
      .trace_req (trace_req)
   );

   lb_readback #(
      .TRACE_AW(TRACE_AW)
   ) lb_readback_inst (
      .fp_clk     (fp_clk),
      .reset      (reset),
      .lb_cmd     (lb_cmd),
      .trace_req  (trace_req),
      .trace_rdata(trace_rdata),
      .rd_data    (rd_data)
   );

endmodule

//--- hw/trace_capture.sv
module trace_capture #(
   parameter int TRACE_AW = 11
) (
   input  logic                   fp_clk,
   input  logic                   reset,
   input  trace_pkg::trace_word_t trace_in,
   input  logic                   trig,
   input  logic                   trace_req,
   input  logic                   trace_nowait,
   input  logic [TRACE_AW-1:0]    raddr,
   output logic                   trace_done,
   output trace_pkg::trace_word_t trace_rdata
);

   logic                trace_run;
   logic [TRACE_AW-1:0] trace_wadd;
   logic                trace_ending;
   logic                trace_start;

   // Last address of the memory closes the run
   assign trace_ending = trace_run && (trace_wadd == '1);

   // Hold off while done is still up, otherwise the pending request
   // would start a second run over the fresh capture
   assign trace_start = trace_req && !trace_run && !trace_done
                        && (trace_nowait || trig);

   always_ff @(posedge fp_clk) begin
      if (reset) begin
         trace_run  <= 1'b0;
         trace_wadd <= '0;
         trace_done <= 1'b0;
      end else begin
         trace_wadd <= trace_run ? trace_wadd + 1'b1 : '0;

         if (trace_start) begin
            trace_run <= 1'b1;
         end
         if (trace_ending) begin
            trace_run <= 1'b0;
         end

         if (trace_ending) begin
            trace_done <= 1'b1;
         end
         // Done drops once the register side has taken the request down
         if (!trace_req) begin
            trace_done <= 1'b0;
         end
      end
   end

   trace_ram #(
      .TRACE_AW(TRACE_AW)
   ) trace_ram_inst (
      .fp_clk(fp_clk),
      .wen   (trace_run),
      .waddr (trace_wadd),
      .wdata (trace_in),
      .raddr (raddr),
      .rdata (trace_rdata)
   );

   // Write address parks at zero between runs
   a_wadd_idle: assert property (
      @(posedge fp_clk) disable iff (reset)
      !trace_run |-> (trace_wadd == '0)
   );

   // A run only begins against a pending request
   a_run_needs_req: assert property (
      @(posedge fp_clk) disable iff (reset)
      $rose(trace_run) |-> $past(trace_req)
   );

endmodule

//--- hw/trace_pkg.sv
package trace_pkg;

   // GMII receive pins as sampled at the board edge
   typedef struct packed {
      logic [7:0] rxd;
      logic       dv;
      logic       er;
   } gmii_rx_t;

   // Local-bus command
   // A write is one strobe cycle with rd low
   typedef struct packed {
      logic [23:0] addr;
      logic [31:0] wdata;
      logic        rd;
      logic        strobe;
   } lb_cmd_t;

   // One trace sample as stored in the trace memory
   typedef struct packed {
      logic [3:0]  tag;
      logic [17:0] rsvd;
      logic        dv;
      logic        er;
      logic [7:0]  rxd;
   } trace_word_t;

   // Software configuration registers
   typedef struct packed {
      logic [3:0] power_conf;
      logic       an_bypass;
      logic       rd_hack;
      logic       nomangle;
      logic       trace_nowait;
   } ctrl_regs_t;

   // Values after reset; autonegotiation bypass starts enabled
   localparam ctrl_regs_t CTRL_RESET = '{
      power_conf:   4'h0,
      an_bypass:    1'b1,
      rd_hack:      1'b0,
      nomangle:     1'b0,
      trace_nowait: 1'b0
   };

   // Register addresses, matched against addr[7:0]
   localparam logic [7:0] ADDR_POWER  = 8'h76;
   localparam logic [7:0] ADDR_TRACE  = 8'h78;
   localparam logic [7:0] ADDR_LINK   = 8'h79;
   localparam logic [7:0] ADDR_MANGLE = 8'h7a;

   // Fixed readback text
   localparam logic [31:0] TXT_GOOD = "Good";
   localparam logic [31:0] TXT_BYE  = "bye ";
   localparam logic [31:0] TXT_WORL = "Worl";
   localparam logic [31:0] TXT_DAVI = "Davi";
   localparam logic [31:0] TXT_TAIL = {"d!", 16'h0d0a};

   // Marker nibble at the top of every trace word
   localparam logic [3:0] TRACE_TAG = 4'h4;

endpackage

//--- hw/trace_ram.sv
module trace_ram #(
   parameter int TRACE_AW = 11
) (
   input  logic                   fp_clk,
   input  logic                   wen,
   input  logic [TRACE_AW-1:0]    waddr,
   input  trace_pkg::trace_word_t wdata,
   input  logic [TRACE_AW-1:0]    raddr,
   output trace_pkg::trace_word_t rdata
);

   trace_pkg::trace_word_t mem [2**TRACE_AW];

   always_ff @(posedge fp_clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read port, one cycle of latency
   always_ff @(posedge fp_clk) begin
      rdata <= mem[raddr];
   end

endmodule

//--- tb/tb_trace_bus.sv
module tb_trace_bus;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TRACE_AW = 11;
   localparam int DEPTH    = 2**TRACE_AW;
   // Room for four full capture lengths plus the short tests
   localparam longint WATCHDOG_CYCLES = 4 * DEPTH + 4000;

   logic                  fp_clk = 1'b0;
   logic                  reset;
   trace_pkg::gmii_rx_t   gmii_rx;
   trace_pkg::lb_cmd_t    lb_cmd;
   logic [31:0]           rd_data;
   trace_pkg::ctrl_regs_t ctrl;

   trace_pkg::ctrl_regs_t  exp_ctrl;
   trace_pkg::trace_word_t trace_buf [DEPTH];
   logic                   rx_inc;
   int unsigned            cycle = 0;
   int                     word_errs;
   int                     ctrl_errs;
   int                     trace_errs;
   int                     other_errs;

   trace_bus_top #(
      .TRACE_AW(TRACE_AW)
   ) trace_bus_top_inst (
      .fp_clk (fp_clk),
      .reset  (reset),
      .gmii_rx(gmii_rx),
      .lb_cmd (lb_cmd),
      .rd_data(rd_data),
      .ctrl   (ctrl)
   );

   always #2 fp_clk = ~fp_clk;

   always @(posedge fp_clk) begin
      cycle <= cycle + 1;
   end

   // Incrementing receive data while enabled
   always @(posedge fp_clk) begin
      if (rx_inc) begin
         gmii_rx.rxd <= gmii_rx.rxd + 8'd1;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * 4);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
      if (got !== exp) begin
         $display("Fail %0t: %s: got %h expected %h", $time, msg, got, exp);
         word_errs++;
      end
   endtask

   task automatic check_ctrl(input trace_pkg::ctrl_regs_t got,
                             input trace_pkg::ctrl_regs_t exp, input string msg);
      if (got !== exp) begin
         $display("Fail %0t: %s: got %h expected %h", $time, msg, got, exp);
         ctrl_errs++;
      end
   endtask

   task automatic check_trace(input trace_pkg::trace_word_t got,
                              input trace_pkg::trace_word_t exp, input string msg);
      if (got !== exp) begin
         $display("Fail %0t: %s: got %h expected %h", $time, msg, got, exp);
         trace_errs++;
      end
   endtask

   // Single-cycle write strobe
   task automatic lb_write(input logic [23:0] addr, input logic [31:0] data);
      @(posedge fp_clk);
      lb_cmd <= '{addr: addr, wdata: data, rd: 1'b0, strobe: 1'b1};
      @(posedge fp_clk);
      lb_cmd.strobe <= 1'b0;
   endtask

   // Address is held 3 cycles to cover the trace path as well
   task automatic lb_read(input logic [23:0] addr, output logic [31:0] data);
      @(posedge fp_clk);
      lb_cmd.addr   <= addr;
      lb_cmd.rd     <= 1'b1;
      lb_cmd.strobe <= 1'b0;
      repeat (3) @(posedge fp_clk);
      @(negedge fp_clk);
      data = rd_data;
   endtask

   // Streams the whole trace window at one address per cycle
   // with data arriving two cycles behind the address
   task automatic read_trace();
      int a;
      for (a = 0; a < DEPTH + 2; a++) begin
         @(posedge fp_clk);
         if (a < DEPTH) begin
            lb_cmd.addr <= 24'h001000 | 24'(a);
         end
         @(negedge fp_clk);
         if (a >= 2) begin
            trace_buf[a - 2] = rd_data;
         end
      end
   endtask

   // Polls address 2 until the request has cleared
   task automatic wait_capture_end(input int unsigned start, input string what);
      int unsigned limit;
      bit          seen;
      limit = DEPTH + 20;
      seen  = 1'b0;
      @(posedge fp_clk);
      lb_cmd.addr   <= 24'h000002;
      lb_cmd.strobe <= 1'b0;
      while (!seen && (cycle - start) < limit) begin
         @(negedge fp_clk);
         if (rd_data == trace_pkg::TXT_WORL) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         $display("The %s capture did not finish within %0d cycles", what, limit);
         other_errs++;
      end
   endtask

   task automatic verify_ramp(input logic [7:0] base, input string what);
      trace_pkg::trace_word_t exp;
      int                     a;
      for (a = 0; a < DEPTH; a++) begin
         exp     = '0;
         exp.tag = trace_pkg::TRACE_TAG;
         exp.dv  = 1'b1;
         exp.rxd = base + 8'(a);
         check_trace(trace_buf[a], exp, $sformatf("%s trace word %0d", what, a));
      end
   endtask

   task automatic reset_state();
      logic [31:0] word;
      @(negedge fp_clk);
      check_word(rd_data, trace_pkg::TXT_GOOD, "rd_data right after reset");
      check_ctrl(ctrl, exp_ctrl, "ctrl after reset");
      lb_read(24'h000000, word);
      check_word(word, trace_pkg::TXT_GOOD, "address 0 after reset");
      lb_read(24'h000002, word);
      check_word(word, trace_pkg::TXT_WORL, "address 2 after reset");
   endtask

   task automatic text_readback();
      logic [31:0] exp_txt [4];
      logic [31:0] word;
      int          i;
      exp_txt[0] = trace_pkg::TXT_GOOD;
      exp_txt[1] = trace_pkg::TXT_BYE;
      exp_txt[2] = trace_pkg::TXT_WORL;
      exp_txt[3] = trace_pkg::TXT_TAIL;
      for (i = 0; i < 4; i++) begin
         lb_read(24'(i), word);
         check_word(word, exp_txt[i], $sformatf("text at address %0d", i));
         // Only bit 12 and bits 1:0 select
         lb_read(24'he00ef0 | 24'(i), word);
         check_word(word, exp_txt[i], $sformatf("text at aliased address %0d", i));
      end
   endtask

   task automatic config_writes();
      logic [7:0]  lo;
      logic [31:0] data;
      logic [31:0] word;
      int          kind;
      int          i;
      for (i = 0; i < 24; i++) begin
         kind = $urandom_range(3, 0);
         case (kind)
            0: lo = trace_pkg::ADDR_POWER;
            1: lo = trace_pkg::ADDR_LINK;
            2: lo = trace_pkg::ADDR_MANGLE;
            default: begin
               do begin
                  lo = 8'($urandom);
               end while (lo == trace_pkg::ADDR_POWER || lo == trace_pkg::ADDR_TRACE ||
                          lo == trace_pkg::ADDR_LINK || lo == trace_pkg::ADDR_MANGLE);
            end
         endcase
         data = $urandom;
         case (lo)
            trace_pkg::ADDR_POWER: exp_ctrl.power_conf = data[3:0];
            trace_pkg::ADDR_LINK: begin
               exp_ctrl.rd_hack   = data[1];
               exp_ctrl.an_bypass = data[0];
            end
            trace_pkg::ADDR_MANGLE: exp_ctrl.nomangle = data[0];
            default: ;
         endcase
         lb_write({16'($urandom), lo}, data);
         @(negedge fp_clk);
         check_ctrl(ctrl, exp_ctrl, $sformatf("ctrl after write %h to 0x%h", data, lo));
      end
      // No request may have been raised
      lb_read(24'h000002, word);
      check_word(word, trace_pkg::TXT_WORL, "address 2 after config writes");
   endtask

   task automatic immediate_capture();
      logic [31:0] word;
      int unsigned start;
      @(posedge fp_clk);
      gmii_rx <= '{rxd: 8'($urandom), dv: 1'b1, er: 1'b0};
      rx_inc  <= 1'b1;
      repeat (5) @(posedge fp_clk);
      lb_write({16'h0, trace_pkg::ADDR_TRACE}, 32'h1);
      @(negedge fp_clk);
      start = cycle;
      exp_ctrl.trace_nowait = 1'b1;
      check_ctrl(ctrl, exp_ctrl, "trace_nowait after immediate request");
      lb_read(24'h000002, word);
      check_word(word, trace_pkg::TXT_DAVI, "address 2 with immediate request pending");
      wait_capture_end(start, "immediate");
      read_trace();
      // Start value is free and only the steps of one count
      verify_ramp(trace_buf[0].rxd, "immediate");
   endtask

   task automatic triggered_capture();
      logic [31:0] word;
      logic [7:0]  hold;
      int unsigned start;
      @(posedge fp_clk);
      rx_inc <= 1'b0;
      @(posedge fp_clk);
      hold = 8'($urandom);
      gmii_rx <= '{rxd: hold, dv: 1'b1, er: 1'b0};
      repeat (10) @(posedge fp_clk);
      lb_write({16'h0, trace_pkg::ADDR_TRACE}, 32'h0);
      @(negedge fp_clk);
      exp_ctrl.trace_nowait = 1'b0;
      check_ctrl(ctrl, exp_ctrl, "trace_nowait after triggered request");
      lb_read(24'h000002, word);
      check_word(word, trace_pkg::TXT_DAVI, "address 2 with triggered request pending");
      repeat (50) begin
         @(negedge fp_clk);
         check_word(rd_data, trace_pkg::TXT_DAVI, "address 2 while input is held");
      end
      @(posedge fp_clk);
      rx_inc <= 1'b1;
      @(negedge fp_clk);
      start = cycle;
      wait_capture_end(start, "triggered");
      read_trace();
      // Oldest history sample is the held value and the ramp follows
      verify_ramp(hold, "triggered");
   endtask

   initial begin
      void'($urandom(32'h723ba435));
      reset      = 1'b1;
      lb_cmd     = '0;
      gmii_rx    = '0;
      rx_inc     = 1'b0;
      word_errs  = 0;
      ctrl_errs  = 0;
      trace_errs = 0;
      other_errs = 0;
      exp_ctrl           = '0;
      exp_ctrl.an_bypass = 1'b1;
      repeat (3) @(posedge fp_clk);
      reset <= 1'b0;

      reset_state();
      text_readback();
      config_writes();
      immediate_capture();
      triggered_capture();

      $display("Errors: word %0d, ctrl %0d, trace %0d, other %0d",
               word_errs, ctrl_errs, trace_errs, other_errs);
      if (word_errs + ctrl_errs + trace_errs + other_errs == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
